// ==== src/dmni_defines.svh ====
`ifndef DMNI_DEFINES_SVH
`define DMNI_DEFINES_SVH

// hermes flit and memory word width.
`define DMNI_FLIT_WIDTH 32

// byte address and size counter width.
`define DMNI_ADDR_WIDTH 32

`define DMNI_WORD_BYTES 4

// cycles a grant is held while the other engine waits.
`define DMNI_ARB_SLICE  15

`endif

// ==== src/dmni_pkg.sv ====
`default_nettype none

`include "dmni_defines.svh"

package dmni_pkg;

    typedef enum logic {
        HERMES_OPERATION_SEND    = 1'b0,
        HERMES_OPERATION_RECEIVE = 1'b1
    } hermes_op_t;

    // one-hot receive states.
    typedef enum logic [3:0] {
        HERMES_RECEIVE_HEADER = 4'b0001,
        HERMES_RECEIVE_SIZE   = 4'b0010,
        HERMES_RECEIVE_WAIT   = 4'b0100,
        HERMES_RECEIVE_DATA   = 4'b1000
    } hermes_receive_t;

    // one-hot send states.
    typedef enum logic [3:0] {
        HERMES_SEND_IDLE    = 4'b0001,
        HERMES_SEND_PRELOAD = 4'b0010,
        HERMES_SEND_DATA    = 4'b0100,
        HERMES_SEND_STOP    = 4'b1000
    } hermes_send_t;

    typedef enum logic {
        ARBIT_SEND    = 1'b0,
        ARBIT_RECEIVE = 1'b1
    } arbit_t;

endpackage

`default_nettype wire

// ==== src/dmni_mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dmni_defines.svh"

interface dmni_mem_if;

    logic                           pending;
    logic                           grant;
    logic [`DMNI_ADDR_WIDTH - 1:0]  addr;
    logic [`DMNI_FLIT_WIDTH - 1:0]  wdata;

    modport requester (
        output pending,
        output addr,
        output wdata,
        input  grant
    );

    modport arbiter (
        input  pending,
        input  addr,
        input  wdata,
        output grant
    );

endinterface

`default_nettype wire

// ==== src/hermes_receive.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dmni_defines.svh"

module hermes_receive (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           noc_rx_i,
    input  logic [`DMNI_FLIT_WIDTH - 1:0]  noc_data_i,
    output logic                           noc_credit_o,
    input  logic                           start_i,
    input  dmni_pkg::hermes_op_t           operation_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  address_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  size_i,
    dmni_mem_if.requester                  mem,
    output logic                           active_o,
    output logic                           available_o,
    output logic [`DMNI_FLIT_WIDTH - 1:0]  flits_available_o
);

    import dmni_pkg::*;

    hermes_receive_t state;
    hermes_receive_t next_state;

    logic                          can_receive;
    logic                          start_rx;
    logic [`DMNI_ADDR_WIDTH - 1:0] rx_addr;
    logic [`DMNI_ADDR_WIDTH - 1:0] rx_size;
    logic [`DMNI_FLIT_WIDTH - 1:0] payload_cntr;

    assign can_receive = noc_rx_i && mem.grant;
    assign start_rx    = start_i && (operation_i == HERMES_OPERATION_RECEIVE);

    // chunk address and size taken on software start.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_addr <= '0;
            rx_size <= '0;
        end else if (state == HERMES_RECEIVE_WAIT && start_rx) begin
            rx_addr <= address_i;
            rx_size <= size_i;
        end else if (state == HERMES_RECEIVE_DATA && can_receive) begin
            rx_addr <= rx_addr + `DMNI_ADDR_WIDTH'(`DMNI_WORD_BYTES);
            rx_size <= rx_size - 1'b1;
        end
    end

    // remaining payload of the whole packet.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            payload_cntr <= '0;
        end else if (state == HERMES_RECEIVE_SIZE && noc_rx_i) begin
            payload_cntr <= noc_data_i;
        end else if (state == HERMES_RECEIVE_DATA && can_receive) begin
            payload_cntr <= payload_cntr - 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            HERMES_RECEIVE_HEADER: if (noc_rx_i) next_state = HERMES_RECEIVE_SIZE;
            HERMES_RECEIVE_SIZE:   if (noc_rx_i) next_state = HERMES_RECEIVE_WAIT;
            HERMES_RECEIVE_WAIT:   if (start_rx) next_state = HERMES_RECEIVE_DATA;
            HERMES_RECEIVE_DATA: begin
                if (can_receive) begin
                    if (payload_cntr == `DMNI_FLIT_WIDTH'(1)) begin
                        next_state = HERMES_RECEIVE_HEADER;
                    end else if (rx_size == `DMNI_ADDR_WIDTH'(1)) begin
                        next_state = HERMES_RECEIVE_WAIT;
                    end
                end
            end
            default: next_state = HERMES_RECEIVE_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state <= HERMES_RECEIVE_HEADER;
        end else begin
            state <= next_state;
        end
    end

    // credit follows the grant while data is written.
    assign noc_credit_o = (state == HERMES_RECEIVE_DATA) ? can_receive
                                                         : (state != HERMES_RECEIVE_WAIT);

    assign active_o          = (state == HERMES_RECEIVE_DATA);
    assign available_o       = (state == HERMES_RECEIVE_WAIT);
    assign flits_available_o = payload_cntr;

    assign mem.pending = active_o;
    assign mem.addr    = rx_addr;
    assign mem.wdata   = noc_data_i;

endmodule

`default_nettype wire

// ==== src/hermes_send.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dmni_defines.svh"

module hermes_send (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           noc_ack_i,
    output logic                           noc_tx_o,
    input  logic                           start_i,
    input  dmni_pkg::hermes_op_t           operation_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  address_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  address_2_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  size_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  size_2_i,
    dmni_mem_if.requester                  mem,
    output logic                           active_o
);

    import dmni_pkg::*;

    hermes_send_t state;
    hermes_send_t next_state;

    logic can_send;
    logic can_send_r;
    logic issuing;
    logic last_word;

    logic [`DMNI_ADDR_WIDTH - 1:0] addr;
    logic [`DMNI_ADDR_WIDTH - 1:0] addr_2;
    logic [`DMNI_ADDR_WIDTH - 1:0] size;
    logic [`DMNI_ADDR_WIDTH - 1:0] size_2;
    logic [`DMNI_ADDR_WIDTH - 1:0] addr_r;
    logic [`DMNI_ADDR_WIDTH - 1:0] addr_2_r;
    logic [`DMNI_ADDR_WIDTH - 1:0] size_r;
    logic [`DMNI_ADDR_WIDTH - 1:0] size_2_r;

    assign can_send = noc_ack_i && mem.grant;
    assign issuing  = (state == HERMES_SEND_PRELOAD) || (state == HERMES_SEND_DATA);

    // one word left to issue over both segments.
    assign last_word = (size == `DMNI_ADDR_WIDTH'(1) && size_2 == '0)
                    || (size == '0 && size_2 == `DMNI_ADDR_WIDTH'(1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            can_send_r <= 1'b0;
        end else begin
            can_send_r <= can_send;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr   <= '0;
            addr_2 <= '0;
            size   <= '0;
            size_2 <= '0;
        end else if (state == HERMES_SEND_IDLE) begin
            addr   <= address_i;
            addr_2 <= address_2_i;
            size   <= size_i;
            size_2 <= size_2_i;
        end else if (can_send && issuing) begin
            if (size != '0) begin
                addr <= addr + `DMNI_ADDR_WIDTH'(`DMNI_WORD_BYTES);
                size <= size - 1'b1;
            end else begin
                addr_2 <= addr_2 + `DMNI_ADDR_WIDTH'(`DMNI_WORD_BYTES);
                size_2 <= size_2 - 1'b1;
            end
        end else if (!can_send && can_send_r) begin
            // ack dropped after the address moved on.
            addr   <= addr_r;
            addr_2 <= addr_2_r;
            size   <= size_r;
            size_2 <= size_2_r;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_r   <= '0;
            addr_2_r <= '0;
            size_r   <= '0;
            size_2_r <= '0;
        end else if (can_send) begin
            addr_r   <= addr;
            addr_2_r <= addr_2;
            size_r   <= size;
            size_2_r <= size_2;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            HERMES_SEND_IDLE: begin
                if (start_i && operation_i == HERMES_OPERATION_SEND) begin
                    next_state = HERMES_SEND_PRELOAD;
                end
            end
            HERMES_SEND_PRELOAD: begin
                if (can_send) next_state = last_word ? HERMES_SEND_STOP : HERMES_SEND_DATA;
            end
            HERMES_SEND_DATA: begin
                if (!can_send) begin
                    next_state = HERMES_SEND_PRELOAD;
                end else if (last_word) begin
                    next_state = HERMES_SEND_STOP;
                end
            end
            // a stall here re-reads the last word.
            HERMES_SEND_STOP: next_state = can_send ? HERMES_SEND_IDLE : HERMES_SEND_PRELOAD;
            default:          next_state = HERMES_SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state <= HERMES_SEND_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // flit valid only while send owns memory.
    assign noc_tx_o = ((state == HERMES_SEND_DATA) || (state == HERMES_SEND_STOP)) && mem.grant;
    assign active_o = (state != HERMES_SEND_IDLE);

    assign mem.pending = active_o;
    assign mem.addr    = (size != '0) ? addr : addr_2;

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dmni_defines.svh"

module mem_arbiter (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    dmni_mem_if.arbiter                    tx_mem,
    dmni_mem_if.arbiter                    rx_mem,
    output logic [3:0]                     mem_we_o,
    output logic [`DMNI_ADDR_WIDTH - 1:0]  mem_addr_o,
    output logic [`DMNI_FLIT_WIDTH - 1:0]  mem_data_o
);

    import dmni_pkg::*;

    arbit_t     owner;
    arbit_t     next_owner;
    logic       owner_pending;
    logic       other_pending;
    logic       rearbitrate;
    logic [3:0] timer;

    assign owner_pending = (owner == ARBIT_SEND) ? tx_mem.pending : rx_mem.pending;
    assign other_pending = (owner == ARBIT_SEND) ? rx_mem.pending : tx_mem.pending;

    assign rearbitrate = (tx_mem.pending || rx_mem.pending)
                      && (timer == '0 || !owner_pending);

    // hand over only when the other engine asks.
    assign next_owner = (rearbitrate && other_pending) ? arbit_t'(~owner) : owner;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner <= ARBIT_SEND;
            timer <= '0;
        end else begin
            owner <= next_owner;
            if (next_owner != owner) begin
                timer <= 4'(`DMNI_ARB_SLICE);
            end else if (timer != '0) begin
                timer <= timer - 1'b1;
            end
        end
    end

    assign tx_mem.grant = (owner == ARBIT_SEND);
    assign rx_mem.grant = (owner == ARBIT_RECEIVE);

    assign mem_addr_o = (owner == ARBIT_SEND) ? tx_mem.addr : rx_mem.addr;
    assign mem_data_o = rx_mem.wdata;
    assign mem_we_o   = (owner == ARBIT_RECEIVE && rx_mem.pending) ? 4'hf : 4'h0;

endmodule

`default_nettype wire

// ==== src/dmni_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dmni_defines.svh"

module dmni_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    input  logic                           noc_rx_i,
    output logic                           noc_credit_o,
    input  logic [`DMNI_FLIT_WIDTH - 1:0]  noc_data_i,

    output logic                           noc_tx_o,
    input  logic                           noc_ack_i,
    output logic [`DMNI_FLIT_WIDTH - 1:0]  noc_data_o,

    output logic [3:0]                     mem_we_o,
    output logic [`DMNI_ADDR_WIDTH - 1:0]  mem_addr_o,
    input  logic [`DMNI_FLIT_WIDTH - 1:0]  mem_data_i,
    output logic [`DMNI_FLIT_WIDTH - 1:0]  mem_data_o,

    input  logic                           hermes_start_i,
    input  dmni_pkg::hermes_op_t           hermes_operation_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  hermes_size_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  hermes_size_2_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  hermes_address_i,
    input  logic [`DMNI_ADDR_WIDTH - 1:0]  hermes_address_2_i,
    output logic                           hermes_send_active_o,
    output logic                           hermes_receive_active_o,
    output logic                           hermes_receive_available_o,
    output logic [`DMNI_FLIT_WIDTH - 1:0]  hermes_receive_flits_available_o
);

    dmni_mem_if rx_mem ();
    dmni_mem_if tx_mem ();

    hermes_receive u_receive (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .noc_rx_i          (noc_rx_i),
        .noc_data_i        (noc_data_i),
        .noc_credit_o      (noc_credit_o),
        .start_i           (hermes_start_i),
        .operation_i       (hermes_operation_i),
        .address_i         (hermes_address_i),
        .size_i            (hermes_size_i),
        .mem               (rx_mem.requester),
        .active_o          (hermes_receive_active_o),
        .available_o       (hermes_receive_available_o),
        .flits_available_o (hermes_receive_flits_available_o)
    );

    hermes_send u_send (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .noc_ack_i   (noc_ack_i),
        .noc_tx_o    (noc_tx_o),
        .start_i     (hermes_start_i),
        .operation_i (hermes_operation_i),
        .address_i   (hermes_address_i),
        .address_2_i (hermes_address_2_i),
        .size_i      (hermes_size_i),
        .size_2_i    (hermes_size_2_i),
        .mem         (tx_mem.requester),
        .active_o    (hermes_send_active_o)
    );

    mem_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .tx_mem     (tx_mem.arbiter),
        .rx_mem     (rx_mem.arbiter),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o)
    );

    // read data goes straight out as the send flit.
    assign noc_data_o = mem_data_i;

endmodule

`default_nettype wire

// ==== test/tb_dmni.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dmni_defines.svh"

module tb_dmni;

    import dmni_pkg::*;

    localparam int NUM_SEND        = 6;
    localparam int NUM_RECV        = 4;
    localparam int NUM_BOTH        = 2;
    localparam int TOTAL_WORDS     = NUM_SEND * 16 + NUM_RECV * 10 + NUM_BOTH * 26;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;
    localparam int WAIT_LIMIT      = 2000;

    logic                          clk_i = 1'b0;
    logic                          rst_ni;
    logic                          noc_rx_i;
    logic                          noc_credit_o;
    logic [`DMNI_FLIT_WIDTH - 1:0] noc_data_i;
    logic                          noc_tx_o;
    logic                          noc_ack_i = 1'b0;
    logic [`DMNI_FLIT_WIDTH - 1:0] noc_data_o;
    logic [3:0]                    mem_we_o;
    logic [`DMNI_ADDR_WIDTH - 1:0] mem_addr_o;
    logic [`DMNI_FLIT_WIDTH - 1:0] mem_data_i = '0;
    logic [`DMNI_FLIT_WIDTH - 1:0] mem_data_o;
    logic                          hermes_start_i;
    hermes_op_t                    hermes_operation_i;
    logic [`DMNI_ADDR_WIDTH - 1:0] hermes_size_i;
    logic [`DMNI_ADDR_WIDTH - 1:0] hermes_size_2_i;
    logic [`DMNI_ADDR_WIDTH - 1:0] hermes_address_i;
    logic [`DMNI_ADDR_WIDTH - 1:0] hermes_address_2_i;
    logic                          hermes_send_active_o;
    logic                          hermes_receive_active_o;
    logic                          hermes_receive_available_o;
    logic [`DMNI_FLIT_WIDTH - 1:0] hermes_receive_flits_available_o;

    logic [15:0] lfsr = 16'd85;
    int          errors = 0;
    int          checks = 0;

    // 1 KiB word memory.
    logic [31:0] mem [0:255];
    logic [31:0] rd_word_q;

    // reference model.
    logic [31:0] tx_expected [$];
    logic [31:0] rx_payload [$];
    logic [31:0] exp_mem [int];
    logic [31:0] exp_flit;

    dmni_top dut (
        .clk_i                            (clk_i),
        .rst_ni                           (rst_ni),
        .noc_rx_i                         (noc_rx_i),
        .noc_credit_o                     (noc_credit_o),
        .noc_data_i                       (noc_data_i),
        .noc_tx_o                         (noc_tx_o),
        .noc_ack_i                        (noc_ack_i),
        .noc_data_o                       (noc_data_o),
        .mem_we_o                         (mem_we_o),
        .mem_addr_o                       (mem_addr_o),
        .mem_data_i                       (mem_data_i),
        .mem_data_o                       (mem_data_o),
        .hermes_start_i                   (hermes_start_i),
        .hermes_operation_i               (hermes_operation_i),
        .hermes_size_i                    (hermes_size_i),
        .hermes_size_2_i                  (hermes_size_2_i),
        .hermes_address_i                 (hermes_address_i),
        .hermes_address_2_i               (hermes_address_2_i),
        .hermes_send_active_o             (hermes_send_active_o),
        .hermes_receive_active_o          (hermes_receive_active_o),
        .hermes_receive_available_o       (hermes_receive_available_o),
        .hermes_receive_flits_available_o (hermes_receive_flits_available_o)
    );

    always #10 clk_i = ~clk_i;

    // fibonacci lfsr with taps 16 14 13 11.
    function automatic logic lfsr_bit();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < width; k++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    // registered read with data driven on the falling edge.
    always @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (mem_we_o[b]) begin
                mem[mem_addr_o[9:2]][b * 8 +: 8] <= mem_data_o[b * 8 +: 8];
            end
        end
        rd_word_q <= mem[mem_addr_o[9:2]];
    end

    always @(negedge clk_i) begin
        mem_data_i <= rd_word_q;
    end

    // ack high about three cycles in four.
    always @(negedge clk_i) begin
        noc_ack_i <= rst_ni && (random_bits(2) != '0);
    end

    // noc sink and the one-owner check.
    always @(posedge clk_i) begin
        if (rst_ni && noc_tx_o && noc_ack_i) begin
            checks++;
            if (mem_we_o != 4'h0) begin
                $display("error at %0t: memory written while a flit is sent", $time);
                errors++;
            end
            if (tx_expected.size() == 0) begin
                $display("error at %0t: unexpected flit %h on the NoC", $time, noc_data_o);
                errors++;
            end else begin
                exp_flit = tx_expected.pop_front();
                if (noc_data_o !== exp_flit) begin
                    $display("mismatch at %0t: noc_data_o = %h, expected %h",
                             $time, noc_data_o, exp_flit);
                    errors++;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("checks: %0d, errors: %0d", checks, errors);
    endtask

    // config is held one cycle before the start pulse.
    task automatic start_operation(input hermes_op_t op, input logic [31:0] addr,
                                   input logic [31:0] addr_2, input logic [31:0] size,
                                   input logic [31:0] size_2);
        hermes_operation_i = op;
        hermes_address_i   = addr;
        hermes_address_2_i = addr_2;
        hermes_size_i      = size;
        hermes_size_2_i    = size_2;
        @(negedge clk_i);
        hermes_start_i = 1'b1;
        @(negedge clk_i);
        hermes_start_i = 1'b0;
    endtask

    task automatic fill_segment(input int base, input int size);
        logic [31:0] word;
        for (int k = 0; k < size; k++) begin
            word = random_bits(32);
            mem[base + k] = word;
            tx_expected.push_back(word);
        end
    endtask

    // send segments live in words 0 to 127.
    task automatic launch_send();
        int size_1;
        int size_2;
        int base_1;
        int base_2;
        size_1 = 1 + random_bits(3);
        size_2 = 1 + random_bits(3);
        if (random_bits(2) == '0) begin
            if (random_bits(1) != '0) size_1 = 0;
            else size_2 = 0;
        end
        base_1 = random_bits(5);
        base_2 = 64 + random_bits(5);
        fill_segment(base_1, size_1);
        fill_segment(base_2, size_2);
        start_operation(HERMES_OPERATION_SEND, base_1 << 2, base_2 << 2, size_1, size_2);
    endtask

    task automatic wait_send_done();
        int cycles;
        cycles = 0;
        while (hermes_send_active_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (hermes_send_active_o) begin
            $display("error at %0t: send engine never finished", $time);
            errors++;
        end
        if (tx_expected.size() != 0) begin
            $display("error at %0t: %0d flits were never sent", $time, tx_expected.size());
            errors++;
            tx_expected.delete();
        end
    endtask

    task automatic wait_receive_available();
        int cycles;
        cycles = 0;
        while (!hermes_receive_available_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!hermes_receive_available_o) begin
            $display("error at %0t: receive engine never became available", $time);
            errors++;
        end
    endtask

    task automatic wait_receive_done();
        int cycles;
        cycles = 0;
        while (hermes_receive_active_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (hermes_receive_active_o) begin
            $display("error at %0t: receive engine never finished", $time);
            errors++;
        end
    endtask

    // hermes source with random rx gaps.
    task automatic send_packet(input int n);
        logic [31:0] flits [$];
        logic [31:0] word;
        flits.push_back(random_bits(16));
        flits.push_back(n);
        for (int k = 0; k < n; k++) begin
            word = random_bits(32);
            flits.push_back(word);
            rx_payload.push_back(word);
        end
        while (flits.size() != 0) begin
            @(negedge clk_i);
            if (random_bits(2) != '0) begin
                noc_rx_i   = 1'b1;
                noc_data_i = flits[0];
            end else begin
                noc_rx_i   = 1'b0;
                noc_data_i = random_bits(32);
            end
            @(posedge clk_i);
            if (noc_rx_i && noc_credit_o) begin
                void'(flits.pop_front());
            end
        end
        @(negedge clk_i);
        noc_rx_i = 1'b0;
    endtask

    task automatic check_credit_held();
        repeat (1 + random_bits(2)) begin
            check_value("noc_credit_o", noc_credit_o, 1'b0);
            @(negedge clk_i);
        end
    endtask

    task automatic plan_chunk(input int base, input int size);
        for (int k = 0; k < size; k++) begin
            exp_mem[base + k] = rx_payload.pop_front();
        end
    endtask

    // receive chunks land in words 128 to 255.
    task automatic receive_chunks(input int n, input bit with_send);
        int first;
        int base;
        first = 1 + (random_bits(3) % (n - 1));
        wait_receive_available();
        check_value("hermes_receive_flits_available_o", hermes_receive_flits_available_o, n);
        check_credit_held();
        if (with_send) begin
            launch_send();
        end
        base = 128 + random_bits(5);
        plan_chunk(base, first);
        start_operation(HERMES_OPERATION_RECEIVE, base << 2, '0, first, '0);
        wait_receive_available();
        check_value("hermes_receive_flits_available_o", hermes_receive_flits_available_o,
                    n - first);
        check_credit_held();
        base = 192 + random_bits(5);
        plan_chunk(base, n - first);
        start_operation(HERMES_OPERATION_RECEIVE, base << 2, '0, n - first, '0);
        wait_receive_done();
        check_value("noc_credit_o", noc_credit_o, 1'b1);
        check_value("hermes_receive_available_o", hermes_receive_available_o, 1'b0);
        if (with_send) begin
            wait_send_done();
        end
        foreach (exp_mem[idx]) begin
            check_value($sformatf("mem[%0d]", idx), mem[idx], exp_mem[idx]);
        end
        exp_mem.delete();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        errors++;
        report_counts();
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int n;
        rst_ni             = 1'b0;
        noc_rx_i           = 1'b0;
        noc_data_i         = '0;
        hermes_start_i     = 1'b0;
        hermes_operation_i = HERMES_OPERATION_SEND;
        hermes_size_i      = '0;
        hermes_size_2_i    = '0;
        hermes_address_i   = '0;
        hermes_address_2_i = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hc0de, i[7:0], ~i[7:0]};
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        check_value("noc_tx_o", noc_tx_o, 1'b0);
        check_value("mem_we_o", mem_we_o, 4'h0);
        check_value("hermes_send_active_o", hermes_send_active_o, 1'b0);
        check_value("hermes_receive_active_o", hermes_receive_active_o, 1'b0);
        check_value("hermes_receive_available_o", hermes_receive_available_o, 1'b0);
        check_value("noc_credit_o", noc_credit_o, 1'b1);

        repeat (NUM_SEND) begin
            launch_send();
            wait_send_done();
        end

        repeat (NUM_RECV) begin
            n = 2 + (random_bits(3) % 7);
            fork
                send_packet(n);
                receive_chunks(n, 1'b0);
            join
        end

        // send and receive share the memory port.
        repeat (NUM_BOTH) begin
            n = 2 + (random_bits(3) % 7);
            fork
                send_packet(n);
                receive_chunks(n, 1'b1);
            join
        end

        repeat (4) @(negedge clk_i);
        report_counts();
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/dmni_pkg.sv
src/dmni_mem_if.sv
src/hermes_receive.sv
src/hermes_send.sv
src/mem_arbiter.sv
src/dmni_top.sv
test/tb_dmni.sv

// ==== Bender.yml ====
package:
  name: dmni

sources:
  - include_dirs:
      - src
    files:
      - src/dmni_pkg.sv
      - src/dmni_mem_if.sv
      - src/hermes_receive.sv
      - src/hermes_send.sv
      - src/mem_arbiter.sv
      - src/dmni_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_dmni.sv
